// File: wiscFrontEnd_params.svh
//////////////////////////////////////////////////
// Front-end parameters: predictor table size,
// execute queue credits and the first fetch address
//////////////////////////////////////////////////
`ifndef WISC_FRONT_END_PARAMS_SVH
`define WISC_FRONT_END_PARAMS_SVH

//////////////////////////////////////////////////
// Branch predictor
//////////////////////////////////////////////////
`define BP_INDEX_BITS 4          // BHT and BTB index width, 16 entries each

//////////////////////////////////////////////////
// Fetch
//////////////////////////////////////////////////
`define CREDIT_MAX    4          // Depth of the execute input queue
`define RESET_PC      16'h0000   // First fetch address

`endif

// File: wiscFrontEndPkg.sv
//////////////////////////////////////////////////
// Front-end types: address, instruction, opcodes
// and the bundles passed between the blocks
//////////////////////////////////////////////////
package wiscFrontEndPkg;

    typedef logic [15:0] addrT;   // Byte address, instructions are 2 bytes
    typedef logic [15:0] instrT;  // Opcode in bits 15:12
    typedef logic [1:0]  bhtCntT; // 2-bit saturating counter

    typedef enum logic [3:0] {
        ADD, SUB, XOR, RED, SLL, SRA, ROR, PADDSB,
        LW, SW, LLB, LHB, B, BR, PCS, HLT
    } opcodeT;

    typedef struct packed {
        logic   valid;
        addrT   pc;
        instrT  instr;
        logic   predTaken;   // Prediction made at fetch
        addrT   predTarget;  // BTB entry read at fetch
    } ifIdT;

    typedef struct packed {
        logic   valid;
        addrT   pc;
        opcodeT aluOp;
        logic   aluSrc;      // Immediate operand
        logic   regSrc;      // Read port 1 takes rd
        logic   zEn;
        logic   nvEn;
        logic   memEnable;
        logic   memWrite;
        logic   regWrite;
        logic   memToReg;
        logic   branch;
        logic   pcs;
        logic   hlt;
    } ctrlBundleT;

    typedef struct packed {
        logic actualTaken;
        addrT actualTarget;
    } resolveT;

    typedef struct packed {
        logic valid;
        addrT pc;
    } redirectT;

    typedef struct packed {
        logic wenBht;
        logic wenBtb;
        addrT pc;            // Branch address, selects the entry
        logic taken;
        addrT target;
    } bpUpdateT;

    typedef struct packed {
        logic valid;
        logic addr;          // 0 enable, 1 clear
        logic data;
    } cfgWriteT;

endpackage

// File: predictorConfig.sv
//////////////////////////////////////////////////
// Predictor config registers: enable flag, clear pulse
//////////////////////////////////////////////////
`timescale 1ns/1ps

module predictorConfig
    import wiscFrontEndPkg::*;
(
    input  logic     clk,
    input  logic     arstN,
    input  cfgWriteT cfgWrite,       // Register write from the host side
    output logic     predictEnable,  // Prediction on
    output logic     tableClear      // One-cycle clear of BHT and BTB
);

    logic enableWr;  // Write to address 0
    logic clearWr;   // Clear command on address 1

    assign enableWr = cfgWrite.valid && !cfgWrite.addr;
    assign clearWr  = cfgWrite.valid && cfgWrite.addr && cfgWrite.data;

    //////////////////////////////////////////////////
    // Enable flag, on after reset
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            predictEnable <= 1'b1;
        end else if (enableWr) begin
            predictEnable <= cfgWrite.data;  // Holds until next write
        end
    end

    // Clear pulse, high for exactly the cycle after the command
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            tableClear <= 1'b0;
        end else begin
            tableClear <= clearWr;  // Self-clearing
        end
    end

endmodule

// File: branchPredictor.sv
//////////////////////////////////////////////////
// Branch predictor: 2-bit BHT counters and BTB targets
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "wiscFrontEnd_params.svh"

module branchPredictor
    import wiscFrontEndPkg::*;
(
    input  logic     clk,
    input  logic     arstN,
    input  addrT     lookupPc,       // Current fetch address
    output logic     predTaken,
    output addrT     predTarget,
    input  bpUpdateT bpUpdate,       // Resolved branch from decode
    input  logic     predictEnable,
    input  logic     tableClear
);

    localparam int     Entries = 1 << `BP_INDEX_BITS;
    localparam bhtCntT CntInit = 2'b01;  // Weakly not taken

    bhtCntT bht [Entries];
    addrT   btb [Entries];

    logic [`BP_INDEX_BITS-1:0] lookupIdx;
    logic [`BP_INDEX_BITS-1:0] updIdx;
    bhtCntT                    curCnt;   // Counter being updated
    bhtCntT                    updCnt;   // Its next value

    // Bit 0 is always zero for 2-byte instructions
    assign lookupIdx = lookupPc[`BP_INDEX_BITS:1];
    assign updIdx    = bpUpdate.pc[`BP_INDEX_BITS:1];

    //////////////////////////////////////////////////
    // Lookup, combinational
    //////////////////////////////////////////////////
    assign predTaken  = predictEnable && bht[lookupIdx][1];  // Upper bit is the guess
    assign predTarget = btb[lookupIdx];

    //////////////////////////////////////////////////
    // Counter step toward the outcome
    //////////////////////////////////////////////////
    always_comb begin
        curCnt = bht[updIdx];
        updCnt = curCnt;
        if (bpUpdate.taken && (curCnt != 2'b11)) begin
            updCnt = curCnt + 2'd1;  // Toward strongly taken
        end else if (!bpUpdate.taken && (curCnt != 2'b00)) begin
            updCnt = curCnt - 2'd1;  // Toward strongly not taken
        end
    end

    //////////////////////////////////////////////////
    // Table write, clear wins over update
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < Entries; i++) begin
                bht[i] <= CntInit;
                btb[i] <= '0;
            end
        end else if (tableClear) begin
            for (int i = 0; i < Entries; i++) begin
                bht[i] <= CntInit;
                btb[i] <= '0;
            end
        end else begin
            if (bpUpdate.wenBht) begin
                bht[updIdx] <= updCnt;
            end
            if (bpUpdate.wenBtb) begin
                btb[updIdx] <= bpUpdate.target;  // Learned target
            end
        end
    end

    // A target is only relearned for a branch that also trains its counter
    assert property (@(posedge clk) disable iff (!arstN)
        bpUpdate.wenBtb |-> bpUpdate.wenBht)
        else $error("BTB write without BHT write");

endmodule

// File: fetchUnit.sv
//////////////////////////////////////////////////
// Fetch: PC, next-PC choice, credits, halt latch
// and the IF/ID register
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "wiscFrontEnd_params.svh"

module fetchUnit
    import wiscFrontEndPkg::*;
(
    input  logic     clk,
    input  logic     arstN,
    output addrT     fetchPc,
    output logic     fetchReq,
    input  instrT    instrWord,     // Same-cycle answer from memory
    input  logic     predTaken,
    input  addrT     predTarget,
    input  redirectT redirect,      // Mispredict from decode
    input  logic     haltSeen,      // Valid HLT in decode
    input  logic     creditReturn,  // One slot freed in execute queue
    output ifIdT     ifId
);

    // One spare code so an overflow stays visible
    localparam int CreditBits = $clog2(`CREDIT_MAX + 2);

    addrT                  pcQ;
    addrT                  pcNext;
    logic [CreditBits-1:0] creditCnt;
    logic                  haltQ;
    logic                  loadEn;    // Fetched word goes into IF/ID

    logic  ifIdValid;
    addrT  ifIdPc;
    instrT ifIdInstr;
    logic  ifIdPredTaken;
    addrT  ifIdPredTarget;

    assign fetchPc  = pcQ;
    assign fetchReq = !haltQ && (creditCnt != '0);
    // Wrong-path word and the word behind a HLT are dropped
    assign loadEn   = fetchReq && !redirect.valid && !haltSeen;

    //////////////////////////////////////////////////
    // Next PC: redirect, then prediction, then PC+2
    //////////////////////////////////////////////////
    always_comb begin
        pcNext = pcQ;  // Hold on stall
        if (redirect.valid) begin
            pcNext = redirect.pc;
        end else if (loadEn) begin
            pcNext = predTaken ? predTarget : pcQ + 16'd2;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pcQ       <= `RESET_PC;
            creditCnt <= CreditBits'(`CREDIT_MAX);
            haltQ     <= 1'b0;
            ifIdValid <= 1'b0;
        end else begin
            pcQ       <= pcNext;
            ifIdValid <= loadEn;  // Bubble when nothing loads
            if (haltSeen) begin
                haltQ <= 1'b1;  // Sticky until reset
            end
            case ({loadEn, creditReturn})
                2'b10:   creditCnt <= creditCnt - 1'b1;  // Spend
                2'b01:   creditCnt <= creditCnt + 1'b1;  // Return
                default: creditCnt <= creditCnt;
            endcase
        end
    end

    // IF/ID payload
    always_ff @(posedge clk) begin
        if (loadEn) begin
            ifIdPc         <= pcQ;
            ifIdInstr      <= instrWord;
            ifIdPredTaken  <= predTaken;
            ifIdPredTarget <= predTarget;
        end
    end

    always_comb begin
        ifId.valid      = ifIdValid;
        ifId.pc         = ifIdPc;
        ifId.instr      = ifIdInstr;
        ifId.predTaken  = ifIdPredTaken;
        ifId.predTarget = ifIdPredTarget;
    end

    // Execute side never returns more credits than were spent
    assert property (@(posedge clk) disable iff (!arstN)
        creditCnt <= CreditBits'(`CREDIT_MAX))
        else $error("Credit count above CREDIT_MAX");

    assert property (@(posedge clk) disable iff (!arstN)
        loadEn |=> ifId.valid && ($past(creditCnt) != '0))
        else $error("IF/ID loaded with no credit");

endmodule

// File: controlUnit.sv
//////////////////////////////////////////////////
// Control unit: opcode decode, branch check,
// redirect and predictor update requests
//////////////////////////////////////////////////
`timescale 1ns/1ps

module controlUnit
    import wiscFrontEndPkg::*;
(
    input  ifIdT       ifId,
    input  resolveT    resolve,   // Branch outcome from the ALU
    output ctrlBundleT ctrlOut,
    output redirectT   redirect,
    output bpUpdateT   bpUpdate,
    output logic       haltSeen
);

    opcodeT opcode;
    logic   isBranch;    // Valid B or BR
    logic   dirMiss;     // Direction guessed wrong
    logic   targetMiss;  // BTB target stale

    assign opcode = opcodeT'(ifId.instr[15:12]);

    //////////////////////////////////////////////////
    // Decode table
    //////////////////////////////////////////////////
    always_comb begin
        ctrlOut           = '0;
        ctrlOut.valid     = ifId.valid;
        ctrlOut.pc        = ifId.pc;
        ctrlOut.aluOp     = opcode;  // ALU sees raw opcode
        ctrlOut.regWrite  = 1'b1;    // Most ops write back
        case (opcode)
            ADD, SUB: begin
                ctrlOut.zEn  = 1'b1;
                ctrlOut.nvEn = 1'b1;
            end
            XOR: begin
                ctrlOut.zEn = 1'b1;
            end
            RED, PADDSB: begin
                // Plain register op, no flags
            end
            SLL, SRA, ROR: begin
                ctrlOut.aluSrc = 1'b1;  // Shift amount from imm
                ctrlOut.zEn    = 1'b1;
            end
            LW: begin
                ctrlOut.aluSrc    = 1'b1;  // Base plus offset
                ctrlOut.memEnable = 1'b1;
                ctrlOut.memToReg  = 1'b1;
            end
            SW: begin
                ctrlOut.aluSrc    = 1'b1;
                ctrlOut.memEnable = 1'b1;
                ctrlOut.memWrite  = 1'b1;
                ctrlOut.memToReg  = 1'b1;  // Unused, no writeback
                ctrlOut.regWrite  = 1'b0;
            end
            LLB, LHB: begin
                ctrlOut.aluSrc = 1'b1;
                ctrlOut.regSrc = 1'b1;  // rd also read
            end
            B, BR: begin
                ctrlOut.branch   = 1'b1;
                ctrlOut.regWrite = 1'b0;
            end
            PCS: begin
                ctrlOut.pcs = 1'b1;  // Writes PC+2
            end
            HLT: begin
                ctrlOut.hlt      = 1'b1;
                ctrlOut.regWrite = 1'b0;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Branch resolution
    //////////////////////////////////////////////////
    assign isBranch   = ifId.valid && ctrlOut.branch;
    assign dirMiss    = ifId.predTaken != resolve.actualTaken;
    assign targetMiss = ifId.predTarget != resolve.actualTarget;

    always_comb begin
        redirect.valid = isBranch && (dirMiss || targetMiss);
        redirect.pc    = resolve.actualTaken ? resolve.actualTarget
                                             : ifId.pc + 16'd2;  // Fall through
    end

    always_comb begin
        bpUpdate.wenBht = isBranch;                // Train on every branch
        bpUpdate.wenBtb = isBranch && targetMiss;  // Fix stale target
        bpUpdate.pc     = ifId.pc;
        bpUpdate.taken  = resolve.actualTaken;
        bpUpdate.target = resolve.actualTarget;
    end

    assign haltSeen = ifId.valid && ctrlOut.hlt;

endmodule

// File: wiscFrontEnd.sv
//////////////////////////////////////////////////
// Front-end top: config, predictor, fetch, decode
//////////////////////////////////////////////////
`timescale 1ns/1ps

module wiscFrontEnd
    import wiscFrontEndPkg::*;
(
    input  logic       clk,
    input  logic       arstN,
    output addrT       fetchPc,       // Instruction memory address
    output logic       fetchReq,
    input  instrT      instrWord,
    input  resolveT    resolve,       // From the ALU
    input  logic       creditReturn,  // From the execute queue
    input  cfgWriteT   cfgWrite,
    output ctrlBundleT ctrlOut        // To execute
);

    logic     predictEnable;
    logic     tableClear;
    logic     predTaken;
    addrT     predTarget;
    redirectT redirect;
    bpUpdateT bpUpdate;
    logic     haltSeen;
    ifIdT     ifId;

    predictorConfig uCfg (
        .clk           (clk),
        .arstN         (arstN),
        .cfgWrite      (cfgWrite),
        .predictEnable (predictEnable),
        .tableClear    (tableClear)
    );

    branchPredictor uBp (
        .clk           (clk),
        .arstN         (arstN),
        .lookupPc      (fetchPc),
        .predTaken     (predTaken),
        .predTarget    (predTarget),
        .bpUpdate      (bpUpdate),
        .predictEnable (predictEnable),
        .tableClear    (tableClear)
    );

    fetchUnit uFetch (
        .clk          (clk),
        .arstN        (arstN),
        .fetchPc      (fetchPc),
        .fetchReq     (fetchReq),
        .instrWord    (instrWord),
        .predTaken    (predTaken),
        .predTarget   (predTarget),
        .redirect     (redirect),
        .haltSeen     (haltSeen),
        .creditReturn (creditReturn),
        .ifId         (ifId)
    );

    controlUnit uCtrl (
        .ifId     (ifId),
        .resolve  (resolve),
        .ctrlOut  (ctrlOut),
        .redirect (redirect),
        .bpUpdate (bpUpdate),
        .haltSeen (haltSeen)
    );

endmodule

// File: tbWiscFrontEnd.sv
//////////////////////////////////////////////////
// Front-end testbench: program memory, ALU responder,
// BHT/BTB reference model, credit model and checks
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "wiscFrontEnd_params.svh"

module tbWiscFrontEnd
    import wiscFrontEndPkg::*;
();

    localparam int TestCycles = 400;                 // Budget over all tests
    localparam int WatchdogNs = TestCycles * 4 * 8;

    logic clk;
    logic arstN;
    addrT fetchPc;
    logic fetchReq;
    instrT instrWord;
    resolveT resolve;
    logic creditReturn;
    cfgWriteT cfgWrite;
    ctrlBundleT ctrlOut;

    instrT  prog [128];       // Program memory, word indexed
    int     takeCnt [128];    // Taken outcomes left per branch
    addrT   brTarget [128];
    bhtCntT modelBht [16];
    addrT   modelBtb [16];
    logic   modelEn;
    int     outstanding;      // Bundles not yet returned as credits
    logic   halted;
    logic   pendRedir;
    addrT   pendPc;
    addrT   expPc;            // Next architectural PC
    logic   expLoad;          // IF/ID loads at the next edge
    logic   rstReq;
    logic   holdCredits;
    cfgWriteT cfgReq;
    integer seed = 49762;
    integer rnd;

    wiscFrontEnd uut (
        .clk          (clk),
        .arstN        (arstN),
        .fetchPc      (fetchPc),
        .fetchReq     (fetchReq),
        .instrWord    (instrWord),
        .resolve      (resolve),
        .creditReturn (creditReturn),
        .cfgWrite     (cfgWrite),
        .ctrlOut      (ctrlOut)
    );

    always #4 clk = ~clk;

    task automatic stopRun(string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic checkBundle(ctrlBundleT got, ctrlBundleT exp);
        if (got !== exp) begin
            stopRun($sformatf("[ERROR] ctrlOut got %h expected %h", got, exp));
        end
    endtask

    task automatic checkAddr(string name, addrT got, addrT exp);
        if (got !== exp) begin
            stopRun($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic checkBit(string name, logic got, logic exp);
        if (got !== exp) begin
            stopRun($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
        end
    endtask

    //////////////////////////////////////////////////
    // Reference decode from the ISA table
    //////////////////////////////////////////////////
    function automatic ctrlBundleT expectedBundle(instrT instr, addrT pc);
        opcodeT op;
        ctrlBundleT b;
        op = opcodeT'(instr[15:12]);
        b = '0;
        b.valid     = 1'b1;
        b.pc        = pc;
        b.aluOp     = op;
        b.regWrite  = !(op inside {SW, B, BR, HLT});  // No writeback
        b.aluSrc    = op inside {SLL, SRA, ROR, LW, SW, LLB, LHB};
        b.regSrc    = op inside {LLB, LHB};
        b.zEn       = op inside {ADD, SUB, XOR, SLL, SRA, ROR};
        b.nvEn      = op inside {ADD, SUB};
        b.memEnable = op inside {LW, SW};
        b.memWrite  = (op == SW);
        b.memToReg  = op inside {LW, SW};
        b.branch    = op inside {B, BR};
        b.pcs       = (op == PCS);
        b.hlt       = (op == HLT);
        return b;
    endfunction

    // Unused words hold HLT with the word index in the low bits
    task automatic clearProgram();
        for (int i = 0; i < 128; i++) begin
            prog[i]     = {HLT, 4'h0, 8'(i)};
            takeCnt[i]  = 0;
            brTarget[i] = addrT'(i * 2 + 2);
        end
    endtask

    task automatic putInstr(int idx, opcodeT op, int taken, addrT tgt);
        prog[idx]     = {op, 12'h0a5 ^ 12'(idx)};
        takeCnt[idx]  = taken;
        brTarget[idx] = tgt;
    endtask

    task automatic loadLoop(int passes);
        clearProgram();
        putInstr(0, ADD, 0, 16'h0002);
        putInstr(1, SUB, 0, 16'h0004);
        putInstr(2, B, passes, 16'h0002);  // Back to SUB, then falls to HLT
    endtask

    //////////////////////////////////////////////////
    // Falling-edge driver and checker
    //////////////////////////////////////////////////
    always @(negedge clk) begin
        if (rstReq) begin
            arstN        = 1'b0;
            outstanding  = 0;
            creditReturn = 1'b0;
            halted       = 1'b0;
            pendRedir    = 1'b0;
            expPc        = `RESET_PC;
            modelEn      = 1'b1;
            resolve      = '0;
            for (int i = 0; i < 16; i++) begin
                modelBht[i] = 2'b01;
                modelBtb[i] = '0;
            end
        end else if (!arstN) begin
            // Reset state, seen just before release
            checkBit("ctrlOut.valid", ctrlOut.valid, 1'b0);
            checkAddr("fetchPc", fetchPc, `RESET_PC);
            checkBit("fetchReq", fetchReq, 1'b1);
            arstN   = 1'b1;
            expLoad = 1'b1;  // First word loads right after release
        end else begin
            outstanding = outstanding - int'(creditReturn) + int'(ctrlOut.valid);
            if (outstanding > `CREDIT_MAX) begin
                stopRun("More bundles outstanding than the execute queue can hold");
            end
            if (pendRedir) begin
                checkAddr("fetchPc after redirect", fetchPc, pendPc);
                pendRedir = 1'b0;
            end
            // Fetch asks only with a free credit and before any HLT
            checkBit("fetchReq", fetchReq, !halted && (outstanding < `CREDIT_MAX));
            resolve = '0;
            if (ctrlOut.valid && halted) begin
                stopRun("A valid bundle appeared after HLT");
            end
            checkBit("ctrlOut.valid", ctrlOut.valid, expLoad);
            if (ctrlOut.valid) begin
                checkBundle(ctrlOut, expectedBundle(prog[expPc[7:1]], expPc));
                if (ctrlOut.branch) begin
                    resolveBranch();
                end else begin
                    expPc = expPc + 16'd2;
                end
                if (ctrlOut.hlt) begin
                    halted = 1'b1;
                end
            end
            rnd          = $random(seed);
            creditReturn = (outstanding > 0) && !holdCredits && rnd[0];
            // Load needs a credit, no redirect and no HLT in decode
            expLoad      = !halted && !pendRedir && (outstanding < `CREDIT_MAX);
        end
        instrWord = prog[fetchPc[7:1]];  // Memory answers in the same cycle
        cfgWrite  = cfgReq;
        if (cfgReq.valid && !cfgReq.addr) begin
            modelEn = cfgReq.data;
        end else if (cfgReq.valid && cfgReq.data) begin
            for (int i = 0; i < 16; i++) begin
                modelBht[i] = 2'b01;
                modelBtb[i] = '0;
            end
        end
        cfgReq.valid = 1'b0;
    end

    // ALU answer plus the predictor model's verdict on this branch
    task automatic resolveBranch();
        logic [3:0] idx;
        logic taken;
        logic pred;
        addrT tgt;
        addrT nextPc;
        idx   = expPc[4:1];
        taken = takeCnt[expPc[7:1]] != 0;
        tgt   = brTarget[expPc[7:1]];
        if (taken) begin
            takeCnt[expPc[7:1]]--;
        end
        resolve.actualTaken  = taken;
        resolve.actualTarget = tgt;
        pred   = modelEn && modelBht[idx][1];
        nextPc = taken ? tgt : expPc + 16'd2;
        if ((pred != taken) || (modelBtb[idx] != tgt)) begin
            pendRedir = 1'b1;
            pendPc    = nextPc;
        end else begin
            checkAddr("fetchPc after predicted branch", fetchPc, nextPc);
        end
        modelBtb[idx] = tgt;
        if (taken && modelBht[idx] != 2'b11) begin
            modelBht[idx] = modelBht[idx] + 2'd1;
        end else if (!taken && modelBht[idx] != 2'b00) begin
            modelBht[idx] = modelBht[idx] - 2'd1;
        end
        expPc = nextPc;
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////
    task automatic resetDut();
        @(posedge clk);
        rstReq = 1'b1;
        repeat (2) @(posedge clk);
        rstReq = 1'b0;
        @(posedge clk);
    endtask

    task automatic writeCfg(logic addr, logic data);
        @(posedge clk);
        cfgReq = '{valid: 1'b1, addr: addr, data: data};
        @(posedge clk);
    endtask

    task automatic checkDrained();
        if (outstanding != `CREDIT_MAX) begin
            stopRun("Fetch did not stop after all credits were spent");
        end
    endtask

    initial begin
        clk          = 1'b0;
        arstN        = 1'b0;
        instrWord    = '0;
        resolve      = '0;
        creditReturn = 1'b0;
        cfgWrite     = '0;
        cfgReq       = '0;
        rstReq       = 1'b1;
        holdCredits  = 1'b0;
        // All 16 opcodes in a row, HLT last
        clearProgram();
        for (int k = 0; k < 15; k++) begin
            putInstr(k, opcodeT'(k), 0, addrT'(k * 2 + 2));
        end
        resetDut();
        wait (halted);
        repeat (6) @(posedge clk);
        loadLoop(5);           // Loop learning
        resetDut();
        wait (halted);
        repeat (6) @(posedge clk);
        loadLoop(20);          // Prediction off, then clear and relearn
        holdCredits = 1'b1;
        resetDut();
        repeat (12) @(posedge clk);
        checkDrained();
        writeCfg(1'b0, 1'b0);
        holdCredits = 1'b0;
        repeat (15) @(posedge clk);
        holdCredits = 1'b1;
        repeat (12) @(posedge clk);
        checkDrained();
        writeCfg(1'b0, 1'b1);
        writeCfg(1'b1, 1'b1);
        repeat (2) @(posedge clk);
        holdCredits = 1'b0;
        wait (halted);
        repeat (6) @(posedge clk);
        $display("No errors");
        $finish;
    end

    initial begin
        #(WatchdogNs);
        stopRun("Watchdog timeout, the tests did not finish in time");
    end

endmodule

// File: wiscFrontEnd.f
+incdir+.
wiscFrontEndPkg.sv
predictorConfig.sv
branchPredictor.sv
fetchUnit.sv
controlUnit.sv
wiscFrontEnd.sv
tbWiscFrontEnd.sv

// File: Makefile
# Verilator build for the front end and its testbench

VERILATOR ?= verilator
FILELIST  ?= wiscFrontEnd.f
TB_TOP    ?= tbWiscFrontEnd
RTL_TOP   ?= wiscFrontEnd
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(shell grep -v '^+' $(FILELIST)) wiscFrontEnd_params.svh
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)
